//--- source/exec_pkg.sv
package exec_pkg;

    // data word and muldiv sizing
    localparam int word_w    = 32;
    localparam int md_iters  = 32;
    localparam int md_cnt_w  = $clog2(md_iters);

    // muldiv unit states
    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_busy = 2'd1;
    localparam logic [1:0] st_done = 2'd2;

    typedef enum logic [3:0] {
        ADD,
        ADDU,
        SUB,
        SUBU,
        AND,
        OR,
        XOR,
        NOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        LUI
    } alu_func_e;

    // second alu operand
    typedef enum logic {
        REGB,
        IMM
    } alu_src_e;

    typedef enum logic [2:0] {
        BEQ,
        BNE,
        BLEZ,
        BGTZ,
        BLTZ,
        BGEZ
    } branch_e;

    typedef enum logic [2:0] {
        MD_NONE,
        MULT,
        MULTU,
        DIV,
        DIVU
    } md_op_e;

    // one instruction word, three decodings
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target;
        } j;
    } instr_u;

endpackage

//--- source/exec_alu.sv
`timescale 1ns/1ns

module exec_alu (
    input  logic [exec_pkg::word_w-1:0] a_i,
    input  logic [exec_pkg::word_w-1:0] b_i,
    input  exec_pkg::alu_func_e         func_i,
    output logic [exec_pkg::word_w-1:0] c_o,
    output logic                        overflow_o
);

    logic [exec_pkg::word_w-1:0] sum;
    logic [exec_pkg::word_w-1:0] diff;
    logic [4:0]                  sh;

    assign sum  = a_i + b_i;
    assign diff = a_i - b_i;
    // shift amount comes in on a, value on b
    assign sh   = a_i[4:0];

    always_comb begin
        c_o = '0;
        unique case (func_i)
            exec_pkg::ADD, exec_pkg::ADDU: c_o = sum;
            exec_pkg::SUB, exec_pkg::SUBU: c_o = diff;
            exec_pkg::AND:  c_o = a_i & b_i;
            exec_pkg::OR:   c_o = a_i | b_i;
            exec_pkg::XOR:  c_o = a_i ^ b_i;
            exec_pkg::NOR:  c_o = ~(a_i | b_i);
            exec_pkg::SLT:  c_o = {31'b0, $signed(a_i) < $signed(b_i)};
            exec_pkg::SLTU: c_o = {31'b0, a_i < b_i};
            exec_pkg::SLL:  c_o = b_i << sh;
            exec_pkg::SRL:  c_o = b_i >> sh;
            exec_pkg::SRA:  c_o = $signed(b_i) >>> sh;
            exec_pkg::LUI:  c_o = {b_i[15:0], 16'b0};
            default:        c_o = '0;
        endcase
    end

    // signed overflow, trapping ops only
    always_comb begin
        overflow_o = 1'b0;
        if (func_i == exec_pkg::ADD) begin
            overflow_o = (a_i[31] == b_i[31]) && (sum[31] != a_i[31]);
        end else if (func_i == exec_pkg::SUB) begin
            overflow_o = (a_i[31] != b_i[31]) && (diff[31] != a_i[31]);
        end
    end

endmodule

//--- source/exec_lane.sv
`timescale 1ns/1ns

module exec_lane (
    input  logic                        valid_i,
    input  logic [exec_pkg::word_w-1:0] pc_i,
    input  exec_pkg::instr_u            instr_i,
    input  logic [exec_pkg::word_w-1:0] rd1_i,
    input  logic [exec_pkg::word_w-1:0] rd2_i,
    input  exec_pkg::alu_func_e         alu_func_i,
    input  exec_pkg::alu_src_e          alu_src_i,
    input  logic                        zero_ext_i,
    input  logic                        shamt_sel_i,
    input  logic                        link_i,
    output logic [exec_pkg::word_w-1:0] alu_out_o,
    output logic                        overflow_o
);

    logic [exec_pkg::word_w-1:0] op_a;
    logic [exec_pkg::word_w-1:0] op_b;
    logic [exec_pkg::word_w-1:0] imm_ext;
    logic [exec_pkg::word_w-1:0] alu_c;
    logic                        alu_ovf;

    // immediate extension
    assign imm_ext = zero_ext_i ? {16'b0, instr_i.i.imm}
                                : {{16{instr_i.i.imm[15]}}, instr_i.i.imm};

    // shift by shamt field or by register
    assign op_a = shamt_sel_i ? {27'b0, instr_i.r.shamt} : rd1_i;

    always_comb begin
        unique case (alu_src_i)
            exec_pkg::REGB: op_b = rd2_i;
            exec_pkg::IMM:  op_b = imm_ext;
            default:        op_b = '0;
        endcase
    end

    exec_alu u_alu (
        .a_i        (op_a),
        .b_i        (op_b),
        .func_i     (alu_func_i),
        .c_o        (alu_c),
        .overflow_o (alu_ovf)
    );

    // link writes the return address past the delay slot
    assign alu_out_o  = link_i ? pc_i + 32'd8 : alu_c;
    assign overflow_o = valid_i & alu_ovf;

    always_comb begin
        a_src_known: assert final (!valid_i || !$isunknown(alu_src_i))
            else $error("lane valid with unknown operand source");
    end

endmodule

//--- source/exec_branch.sv
`timescale 1ns/1ns

module exec_branch (
    input  logic                        branch_i,
    input  exec_pkg::branch_e           branch_type_i,
    input  logic                        jump_i,
    input  logic                        jr_i,
    input  logic [exec_pkg::word_w-1:0] pc_i,
    input  exec_pkg::instr_u            instr_i,
    input  logic [exec_pkg::word_w-1:0] rd1_i,
    input  logic [exec_pkg::word_w-1:0] rd2_i,
    output logic                        taken_o,
    output logic [exec_pkg::word_w-1:0] target_o
);

    logic                        cond;
    logic [exec_pkg::word_w-1:0] slot_pc;
    logic [exec_pkg::word_w-1:0] offset;

    always_comb begin
        unique case (branch_type_i)
            exec_pkg::BEQ:  cond = rd1_i == rd2_i;
            exec_pkg::BNE:  cond = rd1_i != rd2_i;
            exec_pkg::BLEZ: cond = $signed(rd1_i) <= 0;
            exec_pkg::BGTZ: cond = $signed(rd1_i) > 0;
            exec_pkg::BLTZ: cond = rd1_i[31];
            exec_pkg::BGEZ: cond = !rd1_i[31];
            default:        cond = 1'b0;
        endcase
    end

    assign taken_o = jump_i || jr_i || (branch_i && cond);

    // targets are relative to the delay slot
    assign slot_pc = pc_i + 32'd4;
    assign offset  = {{14{instr_i.i.imm[15]}}, instr_i.i.imm, 2'b00};

    always_comb begin
        target_o = '0;
        if (branch_i) begin
            target_o = slot_pc + offset;
        end else if (jr_i) begin
            target_o = rd1_i;
        end else if (jump_i) begin
            target_o = {slot_pc[31:28], instr_i.j.target, 2'b00};
        end
    end

    always_comb begin
        a_one_kind: assert final ($onehot0({branch_i, jump_i, jr_i}))
            else $error("more than one control transfer kind in the slot");
    end

endmodule

//--- source/muldiv_arbiter.sv
`timescale 1ns/1ns

module muldiv_arbiter (
    input  exec_pkg::md_op_e              md_op0_i,
    input  exec_pkg::md_op_e              md_op1_i,
    input  logic [exec_pkg::word_w-1:0]   rd1_0_i,
    input  logic [exec_pkg::word_w-1:0]   rd2_0_i,
    input  logic [exec_pkg::word_w-1:0]   rd1_1_i,
    input  logic [exec_pkg::word_w-1:0]   rd2_1_i,
    input  logic                          done_i,
    input  logic [2*exec_pkg::word_w-1:0] result_i,
    output logic                          req_o,
    output logic                          is_div_o,
    output logic [exec_pkg::word_w-1:0]   a_o,
    output logic [exec_pkg::word_w-1:0]   b_o,
    output logic [2*exec_pkg::word_w-1:0] hilo0_o,
    output logic [2*exec_pkg::word_w-1:0] hilo1_o,
    output logic                          wait_o
);

    logic                          sel1;
    exec_pkg::md_op_e              op;
    logic [exec_pkg::word_w-1:0]   src_a;
    logic [exec_pkg::word_w-1:0]   src_b;
    logic                          is_signed;
    logic                          neg_a;
    logic                          neg_b;
    logic [exec_pkg::word_w-1:0]   quot;
    logic [exec_pkg::word_w-1:0]   rem;
    logic [2*exec_pkg::word_w-1:0] fixed;

    // lane 1 wins when both lanes ask
    assign sel1  = md_op1_i != exec_pkg::MD_NONE;
    assign op    = sel1 ? md_op1_i : md_op0_i;
    assign src_a = sel1 ? rd1_1_i : rd1_0_i;
    assign src_b = sel1 ? rd2_1_i : rd2_0_i;

    assign req_o     = op != exec_pkg::MD_NONE;
    assign is_div_o  = (op == exec_pkg::DIV) || (op == exec_pkg::DIVU);
    assign is_signed = (op == exec_pkg::MULT) || (op == exec_pkg::DIV);

    // unit works on magnitudes
    assign neg_a = is_signed && src_a[31];
    assign neg_b = is_signed && src_b[31];
    assign a_o   = neg_a ? -src_a : src_a;
    assign b_o   = neg_b ? -src_b : src_b;

    // quotient in LO, remainder in HI
    assign quot = (neg_a ^ neg_b) ? -result_i[31:0] : result_i[31:0];
    assign rem  = neg_a ? -result_i[63:32] : result_i[63:32];

    always_comb begin
        if (is_div_o) begin
            fixed = {rem, quot};
        end else begin
            fixed = (neg_a ^ neg_b) ? -result_i : result_i;
        end
    end

    assign hilo1_o = (req_o && done_i && sel1) ? fixed : '0;
    assign hilo0_o = (req_o && done_i && !sel1) ? fixed : '0;
    assign wait_o  = req_o && !done_i;

    always_comb begin
        a_wait_needs_req: assert final (!(wait_o || done_i) || req_o)
            else $error("stall or completion seen with no muldiv request");
    end

endmodule

//--- source/muldiv_unit.sv
`timescale 1ns/1ns

module muldiv_unit (
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    input  logic                          req_i,
    input  logic                          is_div_i,
    input  logic [exec_pkg::word_w-1:0]   a_i,
    input  logic [exec_pkg::word_w-1:0]   b_i,
    output logic                          done_o,
    output logic [2*exec_pkg::word_w-1:0] result_o
);

    logic [1:0]                          state_q;
    logic [exec_pkg::md_cnt_w-1:0]       cnt_q;
    logic                                div_q;
    logic [2*exec_pkg::word_w-1:0]       acc_q;
    logic [exec_pkg::word_w-1:0]         b_q;
    logic [2*exec_pkg::word_w-1:0]       acc_step;
    logic [exec_pkg::word_w:0]           mul_sum;
    logic [2*exec_pkg::word_w:0]         div_shift;
    logic [exec_pkg::word_w:0]           div_diff;
    logic                                start;

    assign start = (state_q == exec_pkg::st_idle) && req_i;

    // one step of either algorithm on the shared accumulator
    always_comb begin
        // multiply: add b into HI when the low multiplier bit is set, then shift right
        mul_sum   = {1'b0, acc_q[63:32]} + (acc_q[0] ? {1'b0, b_q} : 33'd0);
        // divide: shift left, trial subtract from the partial remainder
        div_shift = {acc_q, 1'b0};
        div_diff  = div_shift[64:32] - {1'b0, b_q};
        if (div_q) begin
            if (div_shift[64:32] >= {1'b0, b_q}) begin
                acc_step = {div_diff[31:0], div_shift[31:1], 1'b1};
            end else begin
                acc_step = div_shift[63:0];
            end
        end else begin
            acc_step = {mul_sum, acc_q[31:1]};
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= exec_pkg::st_idle;
            cnt_q   <= '0;
            div_q   <= 1'b0;
        end else begin
            case (state_q)
                exec_pkg::st_idle: begin
                    if (req_i) begin
                        state_q <= exec_pkg::st_busy;
                        cnt_q   <= '0;
                        div_q   <= is_div_i;
                    end
                end
                exec_pkg::st_busy: begin
                    cnt_q <= cnt_q + exec_pkg::md_cnt_w'(1);
                    if (cnt_q == exec_pkg::md_cnt_w'(exec_pkg::md_iters - 1)) begin
                        state_q <= exec_pkg::st_done;
                    end
                end
                default: state_q <= exec_pkg::st_idle;
            endcase
        end
    end

    // operands load with the dividend or multiplier in the low half
    always_ff @(posedge clk_i) begin
        if (start) begin
            acc_q <= {{exec_pkg::word_w{1'b0}}, a_i};
            b_q   <= b_i;
        end else if (state_q == exec_pkg::st_busy) begin
            acc_q <= acc_step;
        end
    end

    assign done_o   = state_q == exec_pkg::st_done;
    assign result_o = acc_q;

    a_done_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        start |-> ##(exec_pkg::md_iters + 1) done_o ##1 !done_o)
        else $error("muldiv done missing after the iterations or held too long");

    a_hold_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        state_q == exec_pkg::st_busy |-> req_i && $stable(is_div_i)
                                         && $stable(a_i) && $stable(b_i))
        else $error("muldiv request or operands changed while busy");

endmodule

//--- source/execute.sv
`timescale 1ns/1ns

module execute (
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    input  logic                          valid_0_i,
    input  logic [exec_pkg::word_w-1:0]   pc_0_i,
    input  exec_pkg::instr_u              instr_0_i,
    input  logic [exec_pkg::word_w-1:0]   rd1_0_i,
    input  logic [exec_pkg::word_w-1:0]   rd2_0_i,
    input  exec_pkg::alu_func_e           alu_func_0_i,
    input  exec_pkg::alu_src_e            alu_src_0_i,
    input  logic                          zero_ext_0_i,
    input  logic                          shamt_sel_0_i,
    input  logic                          link_0_i,
    input  exec_pkg::md_op_e              md_op_0_i,
    input  logic                          valid_1_i,
    input  logic [exec_pkg::word_w-1:0]   pc_1_i,
    input  exec_pkg::instr_u              instr_1_i,
    input  logic [exec_pkg::word_w-1:0]   rd1_1_i,
    input  logic [exec_pkg::word_w-1:0]   rd2_1_i,
    input  exec_pkg::alu_func_e           alu_func_1_i,
    input  exec_pkg::alu_src_e            alu_src_1_i,
    input  logic                          zero_ext_1_i,
    input  logic                          shamt_sel_1_i,
    input  logic                          link_1_i,
    input  exec_pkg::md_op_e              md_op_1_i,
    input  logic                          branch_i,
    input  exec_pkg::branch_e             branch_type_i,
    input  logic                          jump_i,
    input  logic                          jr_i,
    output logic [exec_pkg::word_w-1:0]   alu_out_0_o,
    output logic                          overflow_0_o,
    output logic [2*exec_pkg::word_w-1:0] hilo_0_o,
    output logic [exec_pkg::word_w-1:0]   alu_out_1_o,
    output logic                          overflow_1_o,
    output logic [2*exec_pkg::word_w-1:0] hilo_1_o,
    output logic                          taken_o,
    output logic [exec_pkg::word_w-1:0]   target_o,
    output logic                          wait_o
);

    // arbiter to unit link
    logic                          md_req;
    logic                          md_is_div;
    logic [exec_pkg::word_w-1:0]   md_a;
    logic [exec_pkg::word_w-1:0]   md_b;
    logic                          md_done;
    logic [2*exec_pkg::word_w-1:0] md_result;

    exec_lane u_lane0 (
        .valid_i     (valid_0_i),
        .pc_i        (pc_0_i),
        .instr_i     (instr_0_i),
        .rd1_i       (rd1_0_i),
        .rd2_i       (rd2_0_i),
        .alu_func_i  (alu_func_0_i),
        .alu_src_i   (alu_src_0_i),
        .zero_ext_i  (zero_ext_0_i),
        .shamt_sel_i (shamt_sel_0_i),
        .link_i      (link_0_i),
        .alu_out_o   (alu_out_0_o),
        .overflow_o  (overflow_0_o)
    );

    exec_lane u_lane1 (
        .valid_i     (valid_1_i),
        .pc_i        (pc_1_i),
        .instr_i     (instr_1_i),
        .rd1_i       (rd1_1_i),
        .rd2_i       (rd2_1_i),
        .alu_func_i  (alu_func_1_i),
        .alu_src_i   (alu_src_1_i),
        .zero_ext_i  (zero_ext_1_i),
        .shamt_sel_i (shamt_sel_1_i),
        .link_i      (link_1_i),
        .alu_out_o   (alu_out_1_o),
        .overflow_o  (overflow_1_o)
    );

    // branch slot lives in lane 1
    exec_branch u_branch (
        .branch_i      (branch_i),
        .branch_type_i (branch_type_i),
        .jump_i        (jump_i),
        .jr_i          (jr_i),
        .pc_i          (pc_1_i),
        .instr_i       (instr_1_i),
        .rd1_i         (rd1_1_i),
        .rd2_i         (rd2_1_i),
        .taken_o       (taken_o),
        .target_o      (target_o)
    );

    muldiv_arbiter u_arbiter (
        .md_op0_i (md_op_0_i),
        .md_op1_i (md_op_1_i),
        .rd1_0_i  (rd1_0_i),
        .rd2_0_i  (rd2_0_i),
        .rd1_1_i  (rd1_1_i),
        .rd2_1_i  (rd2_1_i),
        .done_i   (md_done),
        .result_i (md_result),
        .req_o    (md_req),
        .is_div_o (md_is_div),
        .a_o      (md_a),
        .b_o      (md_b),
        .hilo0_o  (hilo_0_o),
        .hilo1_o  (hilo_1_o),
        .wait_o   (wait_o)
    );

    muldiv_unit u_muldiv (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (md_req),
        .is_div_i (md_is_div),
        .a_i      (md_a),
        .b_i      (md_b),
        .done_o   (md_done),
        .result_o (md_result)
    );

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic clk_o,
    output logic arst_n_o
);

    // 20 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #10 clk_o = ~clk_o;
        end
    end

    // reset held low for five rising edges
    initial begin
        arst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

//--- sim/tb_execute.sv
`timescale 1ns/1ns

module tb_execute;

    int unsigned n_alu    = 200;
    int unsigned n_branch = 100;
    int unsigned n_md     = 40;

    // signals carry the DUT port names
    logic                          clk_i;
    logic                          arst_n_i;
    logic                          valid_0_i, valid_1_i;
    logic [exec_pkg::word_w-1:0]   pc_0_i, rd1_0_i, rd2_0_i;
    logic [exec_pkg::word_w-1:0]   pc_1_i, rd1_1_i, rd2_1_i;
    exec_pkg::instr_u              instr_0_i, instr_1_i;
    exec_pkg::alu_func_e           alu_func_0_i, alu_func_1_i;
    exec_pkg::alu_src_e            alu_src_0_i, alu_src_1_i;
    logic                          zero_ext_0_i, shamt_sel_0_i, link_0_i;
    logic                          zero_ext_1_i, shamt_sel_1_i, link_1_i;
    exec_pkg::md_op_e              md_op_0_i, md_op_1_i;
    logic                          branch_i, jump_i, jr_i;
    exec_pkg::branch_e             branch_type_i;
    logic [exec_pkg::word_w-1:0]   alu_out_0_o, alu_out_1_o, target_o;
    logic                          overflow_0_o, overflow_1_o, taken_o, wait_o;
    logic [2*exec_pkg::word_w-1:0] hilo_0_o, hilo_1_o;
    logic                          md_issue;
    int unsigned                   md_age;
    int unsigned                   wait_run;
    int unsigned                   md_completed;
    integer                        seed;

    tb_clock u_clock (
        .clk_o    (clk_i),
        .arst_n_o (arst_n_i)
    );

    execute DUT (.*);

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1, "run stopped");
    endtask

    task automatic value_error(input string what);
        abort_run($sformatf("[ERROR] %0t %s", $time, what));
    endtask

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    // {overflow, result} of one lane, overflow before the valid gate
    function automatic logic [32:0] lane_ref(
        input logic [31:0] pc, input exec_pkg::instr_u instr,
        input logic [31:0] rd1, input logic [31:0] rd2,
        input exec_pkg::alu_func_e func, input exec_pkg::alu_src_e src,
        input logic zext, input logic ssel, input logic link);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [32:0] wide;
        logic        ovf;
        a = ssel ? {27'b0, instr.r.shamt} : rd1;
        if (src == exec_pkg::IMM) begin
            b = zext ? {16'b0, instr.i.imm} : {{16{instr.i.imm[15]}}, instr.i.imm};
        end else begin
            b = rd2;
        end
        ovf = 1'b0;
        c = 32'd0;
        case (func)
            exec_pkg::ADD, exec_pkg::ADDU: begin
                wide = {a[31], a} + {b[31], b};
                c = wide[31:0];
                ovf = (func == exec_pkg::ADD) && (wide[32] != wide[31]);
            end
            exec_pkg::SUB, exec_pkg::SUBU: begin
                wide = {a[31], a} - {b[31], b};
                c = wide[31:0];
                ovf = (func == exec_pkg::SUB) && (wide[32] != wide[31]);
            end
            exec_pkg::AND:  c = a & b;
            exec_pkg::OR:   c = a | b;
            exec_pkg::XOR:  c = a ^ b;
            exec_pkg::NOR:  c = ~(a | b);
            exec_pkg::SLT:  c = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exec_pkg::SLTU: c = (a < b) ? 32'd1 : 32'd0;
            exec_pkg::SLL:  c = b << a[4:0];
            exec_pkg::SRL:  c = b >> a[4:0];
            exec_pkg::SRA:  c = $signed(b) >>> a[4:0];
            exec_pkg::LUI:  c = {b[15:0], 16'b0};
            default:        c = 32'd0;
        endcase
        return {ovf, link ? pc + 32'd8 : c};
    endfunction

    function automatic logic taken_ref(
        input logic br, input exec_pkg::branch_e kind, input logic jump,
        input logic jr, input logic [31:0] rd1, input logic [31:0] rd2);
        logic cond;
        case (kind)
            exec_pkg::BEQ:  cond = rd1 == rd2;
            exec_pkg::BNE:  cond = rd1 != rd2;
            exec_pkg::BLEZ: cond = $signed(rd1) <= 0;
            exec_pkg::BGTZ: cond = $signed(rd1) > 0;
            exec_pkg::BLTZ: cond = $signed(rd1) < 0;
            exec_pkg::BGEZ: cond = $signed(rd1) >= 0;
            default:        cond = 1'b0;
        endcase
        return jump || jr || (br && cond);
    endfunction

    function automatic logic [31:0] target_ref(
        input logic br, input logic jump, input logic jr, input logic [31:0] pc,
        input exec_pkg::instr_u instr, input logic [31:0] rd1);
        logic [31:0] slot;
        slot = pc + 32'd4;
        if (br) begin
            return slot + {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};
        end
        if (jr) begin
            return rd1;
        end
        if (jump) begin
            return {slot[31:28], instr.j.target, 2'b00};
        end
        return 32'd0;
    endfunction

    // HI in the upper half, LO in the lower half
    function automatic logic [63:0] md_ref(
        input exec_pkg::md_op_e op, input logic [31:0] a, input logic [31:0] b);
        logic [31:0] ma;
        logic [31:0] mb;
        logic [31:0] q;
        logic [31:0] r;
        logic        neg_a;
        logic        neg_b;
        if (op == exec_pkg::MULT) begin
            return $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        end
        if (op == exec_pkg::MULTU) begin
            return {32'b0, a} * {32'b0, b};
        end
        if (op == exec_pkg::MD_NONE) begin
            return 64'd0;
        end
        neg_a = (op == exec_pkg::DIV) && a[31];
        neg_b = (op == exec_pkg::DIV) && b[31];
        ma = neg_a ? -a : a;
        mb = neg_b ? -b : b;
        // divide by zero leaves all ones and the dividend
        if (mb == 32'd0) begin
            q = 32'hffff_ffff;
            r = ma;
        end else begin
            q = ma / mb;
            r = ma % mb;
        end
        q = (neg_a != neg_b) ? -q : q;
        r = neg_a ? -r : r;
        return {r, q};
    endfunction

    function automatic logic [31:0] corner_word(input int k);
        case (k)
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'hffff_ffff;
            3:       return 32'h8000_0000;
            default: return 32'h7fff_ffff;
        endcase
    endfunction

    // length of the current stall run, and stalls that have ended
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wait_run     <= 0;
            md_completed <= 0;
        end else if (wait_o) begin
            wait_run <= wait_run + 1;
        end else begin
            if (wait_run != 0) begin
                md_completed <= md_completed + 1;
            end
            wait_run <= 0;
        end
    end

    // cycles since the current muldiv request, result due at 33
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            md_age <= 0;
        end else if (md_issue) begin
            md_age <= 1;
        end else if (md_age != 0 && md_age != 33) begin
            md_age <= md_age + 1;
        end else begin
            md_age <= 0;
        end
    end

    a_lane0: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        {overflow_0_o, alu_out_0_o} == ({valid_0_i, 32'hffff_ffff} & lane_ref(pc_0_i,
            instr_0_i, rd1_0_i, rd2_0_i, alu_func_0_i, alu_src_0_i, zero_ext_0_i,
            shamt_sel_0_i, link_0_i)))
        else value_error($sformatf("lane 0 got %h ovf %b",
            $sampled(alu_out_0_o), $sampled(overflow_0_o)));

    a_lane1: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        {overflow_1_o, alu_out_1_o} == ({valid_1_i, 32'hffff_ffff} & lane_ref(pc_1_i,
            instr_1_i, rd1_1_i, rd2_1_i, alu_func_1_i, alu_src_1_i, zero_ext_1_i,
            shamt_sel_1_i, link_1_i)))
        else value_error($sformatf("lane 1 got %h ovf %b",
            $sampled(alu_out_1_o), $sampled(overflow_1_o)));

    a_branch: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        taken_o == taken_ref(branch_i, branch_type_i, jump_i, jr_i, rd1_1_i, rd2_1_i)
        && target_o == target_ref(branch_i, jump_i, jr_i, pc_1_i, instr_1_i, rd1_1_i))
        else value_error($sformatf("branch got taken %b target %h",
            $sampled(taken_o), $sampled(target_o)));

    // lane 1 served first, the other lane reads zero
    a_md_hilo: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        hilo_1_o == ((md_age == 33) ? md_ref(md_op_1_i, rd1_1_i, rd2_1_i) : 64'd0)
        && hilo_0_o == ((md_age != 33 || md_op_1_i != exec_pkg::MD_NONE) ? 64'd0
                        : md_ref(md_op_0_i, rd1_0_i, rd2_0_i)))
        else value_error($sformatf("hilo got lane1 %h lane0 %h",
            $sampled(hilo_1_o), $sampled(hilo_0_o)));

    a_md_issue: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        md_issue |-> wait_o ##33 !wait_o)
        else value_error("stall did not drop 33 cycles after the request");

    a_md_stall_len: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $fell(wait_o) |-> wait_run == 33)
        else value_error($sformatf("stall lasted %0d cycles", $sampled(wait_run)));

    a_md_idle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wait_o |-> md_op_0_i != exec_pkg::MD_NONE || md_op_1_i != exec_pkg::MD_NONE)
        else value_error("stall raised with no muldiv request");

    task automatic run_alu_vectors();
        int i;
        for (i = 0; i < n_alu; i++) begin
            @(posedge clk_i);
            valid_0_i     <= (i % 5) != 0;
            pc_0_i        <= rand_word() & 32'hffff_fffc;
            instr_0_i     <= rand_word();
            rd1_0_i       <= rand_word();
            rd2_0_i       <= rand_word();
            alu_func_0_i  <= exec_pkg::alu_func_e'(rand_word() % 14);
            alu_src_0_i   <= exec_pkg::alu_src_e'(rand_word() % 2);
            zero_ext_0_i  <= (rand_word() % 2) == 1;
            shamt_sel_0_i <= (rand_word() % 2) == 1;
            link_0_i      <= (rand_word() % 8) == 0;
            valid_1_i     <= (i % 7) != 0;
            pc_1_i        <= rand_word() & 32'hffff_fffc;
            instr_1_i     <= rand_word();
            rd1_1_i       <= rand_word();
            rd2_1_i       <= rand_word();
            alu_func_1_i  <= exec_pkg::alu_func_e'(rand_word() % 14);
            alu_src_1_i   <= exec_pkg::alu_src_e'(rand_word() % 2);
            zero_ext_1_i  <= (rand_word() % 2) == 1;
            shamt_sel_1_i <= (rand_word() % 2) == 1;
            link_1_i      <= (rand_word() % 8) == 0;
        end
    endtask

    // kinds 0..5 are branches, 6 jump, 7 jr
    task automatic run_branch_vectors();
        int i;
        int kind;
        logic [31:0] a;
        logic [31:0] b;
        for (i = 0; i < n_branch; i++) begin
            kind = i % 8;
            a = rand_word();
            b = rand_word();
            case ((i / 8) % 4)
                0:       b = a;
                1:       a = a | 32'h8000_0000;
                2:       a = 32'd0;
                default: a = (a & 32'h7fff_ffff) | 32'd1;
            endcase
            @(posedge clk_i);
            pc_1_i        <= rand_word() & 32'hffff_fffc;
            instr_1_i     <= rand_word();
            rd1_1_i       <= a;
            rd2_1_i       <= b;
            branch_i      <= kind < 6;
            branch_type_i <= exec_pkg::branch_e'(kind % 6);
            jump_i        <= kind == 6;
            jr_i          <= kind == 7;
        end
        @(posedge clk_i);
        branch_i <= 1'b0;
        jump_i   <= 1'b0;
        jr_i     <= 1'b0;
    endtask

    task automatic run_muldiv_ops();
        int i;
        exec_pkg::md_op_e op;
        logic [31:0] a;
        logic [31:0] b;
        for (i = 0; i < n_md; i++) begin
            op = exec_pkg::md_op_e'(1 + i % 4);
            a = (i < 20) ? corner_word(i % 5) : rand_word();
            b = (i < 20) ? corner_word((i / 4) % 5) : rand_word();
            @(posedge clk_i);
            md_issue <= 1'b1;
            case (i % 3)
                0: begin
                    md_op_0_i <= op;
                    md_op_1_i <= exec_pkg::MD_NONE;
                    rd1_0_i   <= a;
                    rd2_0_i   <= b;
                end
                1: begin
                    md_op_0_i <= exec_pkg::MD_NONE;
                    md_op_1_i <= op;
                    rd1_1_i   <= a;
                    rd2_1_i   <= b;
                end
                default: begin
                    // both lanes ask
                    md_op_0_i <= exec_pkg::MULTU;
                    md_op_1_i <= op;
                    rd1_0_i   <= b;
                    rd2_0_i   <= a;
                    rd1_1_i   <= a;
                    rd2_1_i   <= b;
                end
            endcase
            @(posedge clk_i);
            md_issue <= 1'b0;
            do begin
                @(negedge clk_i);
            end while (wait_o);
        end
        @(posedge clk_i);
        md_op_0_i <= exec_pkg::MD_NONE;
        md_op_1_i <= exec_pkg::MD_NONE;
    endtask

    initial begin
        seed          = 32'h099e_df3c;
        md_issue      = 1'b0;
        valid_0_i     = 1'b0;
        valid_1_i     = 1'b0;
        pc_0_i        = '0;
        pc_1_i        = '0;
        instr_0_i     = '0;
        instr_1_i     = '0;
        rd1_0_i       = '0;
        rd2_0_i       = '0;
        rd1_1_i       = '0;
        rd2_1_i       = '0;
        alu_func_0_i  = exec_pkg::ADD;
        alu_func_1_i  = exec_pkg::ADD;
        alu_src_0_i   = exec_pkg::REGB;
        alu_src_1_i   = exec_pkg::REGB;
        zero_ext_0_i  = 1'b0;
        zero_ext_1_i  = 1'b0;
        shamt_sel_0_i = 1'b0;
        shamt_sel_1_i = 1'b0;
        link_0_i      = 1'b0;
        link_1_i      = 1'b0;
        md_op_0_i     = exec_pkg::MD_NONE;
        md_op_1_i     = exec_pkg::MD_NONE;
        branch_i      = 1'b0;
        branch_type_i = exec_pkg::BEQ;
        jump_i        = 1'b0;
        jr_i          = 1'b0;
        wait (arst_n_i === 1'b1);
        // a few idle cycles with no request
        repeat (3) @(posedge clk_i);
        run_alu_vectors();
        run_branch_vectors();
        run_muldiv_ops();
        repeat (3) @(posedge clk_i);
        if (md_completed == n_md) begin
            $display("Regression passed");
            $finish;
        end else begin
            abort_run("not every muldiv operation completed");
        end
    end

    // nominal length plus margin, 120 us in all
    initial begin
        int unsigned cycles;
        cycles = n_alu + n_branch + n_md * 35;
        #((cycles + 4300) * 20);
        abort_run("watchdog expired before the tests finished");
    end

endmodule

//--- compile.f
source/exec_pkg.sv
source/exec_alu.sv
source/exec_lane.sv
source/exec_branch.sv
source/muldiv_arbiter.sv
source/muldiv_unit.sv
source/execute.sv
sim/tb_clock.sv
sim/tb_execute.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_execute
FILELIST   := compile.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing --assert --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# the simulator exit status carries pass or fail
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
